/* source/lsu_config.svh */
// Width and depth macros for the load/store path.
// Included by the RTL and the testbench; types live in the packages.
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// data and address width in bits
`define LSU_DATA_WIDTH 32

// memory depth in 32-bit words
// must stay a power of two, the word index is taken straight from the address
`define LSU_MEM_WORDS 4096

// bytes per word, derived from the data width
`define LSU_WORD_BYTES (`LSU_DATA_WIDTH / 8)

// byte lanes are little-endian
// lane 0 holds bits 7:0 of the word

`endif

/* source/lsuPkg.sv */
// Instruction-side types of the load/store path.
// Referenced by scoped name from the decoder, the stages and the testbench.
`default_nettype none

package lsuPkg;

  // memory opcodes as they arrive from the issue side
  // loads first, then stores, opNone marks an idle slot
  typedef enum logic [3:0] {
    opLdrb  = 4'd0,
    opLdrsb = 4'd1,
    opLdrh  = 4'd2,
    opLdrsh = 4'd3,
    opLdr   = 4'd4,
    opStrb  = 4'd5,
    opStrh  = 4'd6,
    opStr   = 4'd7,
    opNone  = 4'd15
  } memOp;

  // access width seen by the pipeline stages
  // sizeWord is the only size used for full-word loads
  typedef enum logic [1:0] {
    sizeByte = 2'd0,
    sizeHalf = 2'd1,
    sizeWord = 2'd2
  } accessSize;

endpackage

`default_nettype wire

/* source/busPkg.sv */
// Memory-side types of the load/store path.
// Transfer size follows the AHB HSIZE coding; fault cause goes to the outputs.
`default_nettype none

package busPkg;

  // HSIZE style size code on the memory select path
  // only the low two bits matter for a 32-bit memory
  typedef enum logic [2:0] {
    xferByte = 3'b000,
    xferHalf = 3'b001,
    xferWord = 3'b010
  } transferSize;

  // why an access was refused
  // faultAlign wins when both apply
  typedef enum logic [1:0] {
    faultNone  = 2'd0,
    faultAlign = 2'd1,
    faultRange = 2'd2
  } faultCause;

endpackage

`default_nettype wire

/* source/memOpDecoder.sv */
// Decode stage: memory opcode into size, direction and extension controls.
// Purely combinational, feeds the execute stage.
`timescale 1ns/1ps
`default_nettype none

module memOpDecoder (
  input  lsuPkg::memOp      op,
  output logic              isLoad,
  output logic              isStore,
  output lsuPkg::accessSize size,
  output logic              signExt
);

  always_comb begin
    // idle defaults, also cover opNone and unused codes
    isLoad  = 1'b0;
    isStore = 1'b0;
    size    = lsuPkg::sizeWord;
    signExt = 1'b0;
    case (op)
      lsuPkg::opLdrb: begin
        isLoad = 1'b1;
        size   = lsuPkg::sizeByte;
      end
      lsuPkg::opLdrsb: begin
        isLoad  = 1'b1;
        size    = lsuPkg::sizeByte;
        signExt = 1'b1;
      end
      lsuPkg::opLdrh: begin
        isLoad = 1'b1;
        size   = lsuPkg::sizeHalf;
      end
      lsuPkg::opLdrsh: begin
        isLoad  = 1'b1;
        size    = lsuPkg::sizeHalf;
        signExt = 1'b1;
      end
      lsuPkg::opLdr: begin
        isLoad = 1'b1;
        size   = lsuPkg::sizeWord;
      end
      // stores never extend
      lsuPkg::opStrb: begin
        isStore = 1'b1;
        size    = lsuPkg::sizeByte;
      end
      lsuPkg::opStrh: begin
        isStore = 1'b1;
        size    = lsuPkg::sizeHalf;
      end
      lsuPkg::opStr: begin
        isStore = 1'b1;
        size    = lsuPkg::sizeWord;
      end
      default: begin
        isLoad  = 1'b0;
        isStore = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/addressUnit.sv */
// Execute stage: effective address, alignment and range check, access register.
// A faulting access reaches the outputs as a fault pulse and never selects memory.
`timescale 1ns/1ps
`default_nettype none
`include "lsu_config.svh"

module addressUnit (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         req,
  input  logic                         isLoad,
  input  logic                         isStore,
  input  lsuPkg::accessSize            size,
  input  logic                         signExt,
  input  logic [`LSU_DATA_WIDTH-1:0]   base,
  input  logic [`LSU_DATA_WIDTH-1:0]   offset,
  input  logic [`LSU_DATA_WIDTH-1:0]   storeData,
  output logic                         memSel,
  output logic                         we,
  output logic                         re,
  output logic [`LSU_DATA_WIDTH-1:0]   addr,
  output logic [`LSU_DATA_WIDTH-1:0]   wdata,
  output busPkg::transferSize          xferSize,
  output logic                         loadPending,
  output logic [1:0]                   laneSel,
  output lsuPkg::accessSize            sizeOut,
  output logic                         signExtOut,
  output logic                         fault,
  output busPkg::faultCause            faultKind
);

  logic [`LSU_DATA_WIDTH-1:0] effAddr;
  logic [`LSU_DATA_WIDTH-1:0] laneData;
  logic                       access;
  logic                       misaligned;
  logic                       outOfRange;
  logic                       refuse;
  busPkg::transferSize        nextXfer;
  busPkg::faultCause          nextCause;
  // first fault stage, lines the pulse up with the result stage
  logic                       exFault;
  busPkg::faultCause          exFaultKind;

  assign effAddr = base + offset;
  assign access  = req & (isLoad | isStore);

  // halfword needs an even address, word a multiple of 4
  assign misaligned = ((size == lsuPkg::sizeHalf) & effAddr[0]) |
                      ((size == lsuPkg::sizeWord) & (|effAddr[1:0]));
  // word index past the end of the array
  assign outOfRange = effAddr[`LSU_DATA_WIDTH-1:2] >=
                      (`LSU_DATA_WIDTH-2)'(`LSU_MEM_WORDS);
  assign refuse     = access & (misaligned | outOfRange);

  always_comb begin
    // alignment is reported ahead of range
    if (misaligned) nextCause = busPkg::faultAlign;
    else if (outOfRange) nextCause = busPkg::faultRange;
    else nextCause = busPkg::faultNone;
  end

  // access size to HSIZE code, store data copied onto every lane it could use
  always_comb begin
    case (size)
      lsuPkg::sizeByte: begin
        nextXfer = busPkg::xferByte;
        laneData = {4{storeData[7:0]}};
      end
      lsuPkg::sizeHalf: begin
        nextXfer = busPkg::xferHalf;
        laneData = {2{storeData[15:0]}};
      end
      default: begin
        nextXfer = busPkg::xferWord;
        laneData = storeData;
      end
    endcase
  end

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      memSel      <= 1'b0;
      we          <= 1'b0;
      re          <= 1'b0;
      loadPending <= 1'b0;
      exFault     <= 1'b0;
      exFaultKind <= busPkg::faultNone;
      fault       <= 1'b0;
      faultKind   <= busPkg::faultNone;
    end else begin
      memSel      <= access & ~refuse;
      we          <= access & ~refuse & isStore;
      re          <= access & ~refuse & isLoad;
      loadPending <= access & ~refuse & isLoad;
      exFault     <= refuse;
      exFaultKind <= refuse ? nextCause : busPkg::faultNone;
      fault       <= exFault;
      faultKind   <= exFaultKind;
    end
  end

  // payload, only looked at while a strobe above is set
  always_ff @(posedge clk) begin
    addr       <= effAddr;
    wdata      <= laneData;
    xferSize   <= nextXfer;
    laneSel    <= effAddr[1:0];
    sizeOut    <= size;
    signExtOut <= signExt;
  end

endmodule

`default_nettype wire

/* source/dataMemory.sv */
// Byte-addressable word memory, simulation model.
// Sized lane writes by read-modify-write at the clock edge, word read is asynchronous.
`timescale 1ns/1ps
`default_nettype none
`include "lsu_config.svh"

module dataMemory (
  input  logic                       clk,
  input  logic                       memSel,
  input  logic                       we,
  input  logic                       re,
  input  logic [`LSU_DATA_WIDTH-1:0] addr,
  input  logic [`LSU_DATA_WIDTH-1:0] wdata,
  input  busPkg::transferSize        xferSize,
  output logic [`LSU_DATA_WIDTH-1:0] rdata,
  output logic                       valid
);

  localparam int IndexBits = $clog2(`LSU_MEM_WORDS);

  logic [`LSU_DATA_WIDTH-1:0] ram [`LSU_MEM_WORDS];
  logic [IndexBits-1:0]       wordIdx;
  logic [`LSU_DATA_WIDTH-1:0] merged;

  // word index drops the byte offset
  assign wordIdx = addr[IndexBits+1:2];
  assign rdata   = ram[wordIdx];
  assign valid   = re | we;

  // memory starts cleared
  initial begin
    for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
      ram[i] = '0;
    end
  end

  // new word: store lanes from wdata, the rest from the current word
  always_comb begin
    merged = rdata;
    case (xferSize)
      busPkg::xferByte: begin
        case (addr[1:0])
          2'b00: merged = {rdata[31:8], wdata[7:0]};
          2'b01: merged = {rdata[31:16], wdata[15:8], rdata[7:0]};
          2'b10: merged = {rdata[31:24], wdata[23:16], rdata[15:0]};
          default: merged = {wdata[31:24], rdata[23:0]};
        endcase
      end
      busPkg::xferHalf: begin
        // addr[0] is clear, alignment was checked upstream
        if (addr[1]) merged = {wdata[31:16], rdata[15:0]};
        else merged = {rdata[31:16], wdata[15:0]};
      end
      busPkg::xferWord: begin
        merged = wdata;
      end
      default: begin
        // unknown size code leaves the word as it was
        merged = rdata;
      end
    endcase
  end

  // write port
  always @(posedge clk) begin
    if (memSel & we) begin
      ram[wordIdx] <= merged;
    end
  end

endmodule

`default_nettype wire

/* source/loadFormatter.sv */
// Result stage: picks the load lane out of the read word and extends it.
// loadData is registered and loadValid pulses once per load.
`timescale 1ns/1ps
`default_nettype none
`include "lsu_config.svh"

module loadFormatter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       loadPending,
  input  logic [1:0]                 laneSel,
  input  lsuPkg::accessSize          size,
  input  logic                       signExt,
  input  logic [`LSU_DATA_WIDTH-1:0] rdata,
  output logic                       loadValid,
  output logic [`LSU_DATA_WIDTH-1:0] loadData
);

  logic [7:0]                 byteLane;
  logic [15:0]                halfLane;
  logic [`LSU_DATA_WIDTH-1:0] extended;

  // little-endian lane select
  always_comb begin
    case (laneSel)
      2'b00: byteLane = rdata[7:0];
      2'b01: byteLane = rdata[15:8];
      2'b10: byteLane = rdata[23:16];
      default: byteLane = rdata[31:24];
    endcase
  end

  // halfword only ever sits at lane 0 or 2
  assign halfLane = laneSel[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (size)
      lsuPkg::sizeByte: begin
        extended = {{24{signExt & byteLane[7]}}, byteLane};
      end
      lsuPkg::sizeHalf: begin
        extended = {{16{signExt & halfLane[15]}}, halfLane};
      end
      default: begin
        // full word, nothing to extend
        extended = rdata;
      end
    endcase
  end

  // one-cycle pulse per load
  always_ff @(posedge clk) begin
    if (rst) begin
      loadValid <= 1'b0;
    end else begin
      loadValid <= loadPending;
    end
  end

  // result holds until the next load
  always_ff @(posedge clk) begin
    if (loadPending) begin
      loadData <= extended;
    end
  end

endmodule

`default_nettype wire

/* source/lsuTop.sv */
// Top level of the load/store path.
// Wires decode, execute, memory and result stages together.
`timescale 1ns/1ps
`default_nettype none
`include "lsu_config.svh"

module lsuTop (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req,
  input  lsuPkg::memOp               op,
  input  logic [`LSU_DATA_WIDTH-1:0] base,
  input  logic [`LSU_DATA_WIDTH-1:0] offset,
  input  logic [`LSU_DATA_WIDTH-1:0] storeData,
  output logic                       loadValid,
  output logic [`LSU_DATA_WIDTH-1:0] loadData,
  output logic                       fault,
  output busPkg::faultCause          faultKind
);

  // decode to execute
  logic                       decIsLoad;
  logic                       decIsStore;
  lsuPkg::accessSize          decSize;
  logic                       decSignExt;
  // execute to memory
  logic                       memSel;
  logic                       we;
  logic                       re;
  logic [`LSU_DATA_WIDTH-1:0] addr;
  logic [`LSU_DATA_WIDTH-1:0] wdata;
  busPkg::transferSize        xferSize;
  // execute to result
  logic                       loadPending;
  logic [1:0]                 laneSel;
  lsuPkg::accessSize          exSize;
  logic                       exSignExt;
  // memory back to result
  logic [`LSU_DATA_WIDTH-1:0] rdata;

  memOpDecoder uDecode (
    .op      (op),
    .isLoad  (decIsLoad),
    .isStore (decIsStore),
    .size    (decSize),
    .signExt (decSignExt)
  );

  addressUnit uExecute (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .isLoad      (decIsLoad),
    .isStore     (decIsStore),
    .size        (decSize),
    .signExt     (decSignExt),
    .base        (base),
    .offset      (offset),
    .storeData   (storeData),
    .memSel      (memSel),
    .we          (we),
    .re          (re),
    .addr        (addr),
    .wdata       (wdata),
    .xferSize    (xferSize),
    .loadPending (loadPending),
    .laneSel     (laneSel),
    .sizeOut     (exSize),
    .signExtOut  (exSignExt),
    .fault       (fault),
    .faultKind   (faultKind)
  );

  // bus valid has no consumer here
  dataMemory uMemory (
    .clk      (clk),
    .memSel   (memSel),
    .we       (we),
    .re       (re),
    .addr     (addr),
    .wdata    (wdata),
    .xferSize (xferSize),
    .rdata    (rdata),
    .valid    ()
  );

  loadFormatter uResult (
    .clk         (clk),
    .rst         (rst),
    .loadPending (loadPending),
    .laneSel     (laneSel),
    .size        (exSize),
    .signExt     (exSignExt),
    .rdata       (rdata),
    .loadValid   (loadValid),
    .loadData    (loadData)
  );

endmodule

`default_nettype wire

/* verification/lsuTop_chk.sv */
// Protocol assertions for the load/store path, bound into lsuTop.
// Watches the fault, write and load result strobes.
`timescale 1ns/1ps
`default_nettype none

module lsuTop_chk (
  input logic         clk,
  input logic         rst,
  input logic         req,
  input lsuPkg::memOp op,
  input logic         we,
  input logic         fault,
  input logic         loadValid
);

  logic loadReq;

  // any of the five load opcodes
  assign loadReq = req & (op inside {lsuPkg::opLdrb, lsuPkg::opLdrsb, lsuPkg::opLdrh,
                                     lsuPkg::opLdrsh, lsuPkg::opLdr});

  // a refused load never returns data
  faultNotLoad: assert property (@(posedge clk) disable iff (rst) !(fault && loadValid))
    else $error("fault and loadValid high together");

  // the access behind a fault pulse never raised the write strobe
  faultNoWrite: assert property (@(posedge clk) disable iff (rst) fault |-> !$past(we))
    else $error("write strobe raised by a faulting access");

  // result comes two edges after the load was sampled
  loadLatency: assert property (@(posedge clk) disable iff (rst)
    loadValid |-> $past(loadReq, 2))
    else $error("loadValid without a load request two edges earlier");

endmodule

bind lsuTop lsuTop_chk chk (
  .clk       (clk),
  .rst       (rst),
  .req       (req),
  .op        (op),
  .we        (we),
  .fault     (fault),
  .loadValid (loadValid)
);

`default_nettype wire

/* verification/lsuTop_tb.sv */
// Table-driven testbench for lsuTop with a reference memory model.
// Directed rows first, then a random phase over a small address window.
`timescale 1ns/1ps
`default_nettype none
`include "lsu_config.svh"

module lsuTop_tb;

  localparam int RandCount = 200;

  logic clk = 1'b0;
  logic rst;
  logic req;
  lsuPkg::memOp op;
  logic [31:0] base;
  logic [31:0] offset;
  logic [31:0] storeData;
  logic loadValid;
  logic [31:0] loadData;
  logic fault;
  busPkg::faultCause faultKind;

  // stimulus table
  lsuPkg::memOp tabOp[$];
  logic [31:0] tabBase[$];
  logic [31:0] tabOff[$];
  logic [31:0] tabData[$];
  int tableLen = 0;
  // expected results, oldest first; kind 0 idle, 1 load, 2 fault
  int expKind[$];
  logic [31:0] expData[$];
  busPkg::faultCause expCause[$];
  logic [31:0] refMem [`LSU_MEM_WORDS];
  int errors = 0;
  int checks = 0;
  integer seed = 63;

  lsuTop dut (
    .clk(clk), .rst(rst), .req(req), .op(op), .base(base), .offset(offset),
    .storeData(storeData), .loadValid(loadValid), .loadData(loadData),
    .fault(fault), .faultKind(faultKind)
  );

  always #5 clk = ~clk;

  task automatic addRow(lsuPkg::memOp o, logic [31:0] b, logic [31:0] f, logic [31:0] d);
    tabOp.push_back(o);
    tabBase.push_back(b);
    tabOff.push_back(f);
    tabData.push_back(d);
  endtask

  // reference behavior: alignment first, then range, little-endian lanes
  task automatic modelAccess(lsuPkg::memOp o, logic [31:0] a, logic [31:0] d,
                             output int kind, output logic [31:0] data,
                             output busPkg::faultCause cause);
    int bytes;
    bit load;
    bit sext;
    logic [31:0] w;
    kind = 0;
    data = '0;
    cause = busPkg::faultNone;
    load = o inside {lsuPkg::opLdrb, lsuPkg::opLdrsb, lsuPkg::opLdrh,
                     lsuPkg::opLdrsh, lsuPkg::opLdr};
    sext = o inside {lsuPkg::opLdrsb, lsuPkg::opLdrsh};
    if (o inside {lsuPkg::opLdrb, lsuPkg::opLdrsb, lsuPkg::opStrb}) bytes = 1;
    else if (o inside {lsuPkg::opLdrh, lsuPkg::opLdrsh, lsuPkg::opStrh}) bytes = 2;
    else if (o inside {lsuPkg::opLdr, lsuPkg::opStr}) bytes = 4;
    else return;
    if (a % bytes != 0) begin
      kind = 2;
      cause = busPkg::faultAlign;
    end else if ((a >> 2) >= `LSU_MEM_WORDS) begin
      kind = 2;
      cause = busPkg::faultRange;
    end else if (load) begin
      kind = 1;
      w = refMem[a >> 2] >> (8 * a[1:0]);
      if (bytes == 1) data = sext ? {{24{w[7]}}, w[7:0]} : {24'h0, w[7:0]};
      else if (bytes == 2) data = sext ? {{16{w[15]}}, w[15:0]} : {16'h0, w[15:0]};
      else data = w;
    end else begin
      w = refMem[a >> 2];
      for (int i = 0; i < bytes; i++) w[8 * (a[1:0] + i) +: 8] = d[8 * i +: 8];
      refMem[a >> 2] = w;
    end
  endtask

  task automatic checkData(logic expValid, logic [31:0] expected);
    checks++;
    if (loadValid !== expValid) begin
      errors++;
      $display("ERR %0t: loadValid %b, expected %b", $time, loadValid, expValid);
    end else if (expValid && loadData !== expected) begin
      errors++;
      $display("ERR %0t: loadData %h, expected %h", $time, loadData, expected);
    end
  endtask

  task automatic checkFault(busPkg::faultCause expected);
    checks++;
    if (fault !== (expected != busPkg::faultNone) || faultKind !== expected) begin
      errors++;
      $display("ERR %0t: fault %b kind %0d, expected kind %0d", $time, fault,
               faultKind, expected);
    end
  endtask

  // one row per cycle, result of the row two edges back is checked at negedge
  task automatic applyRow(lsuPkg::memOp o, logic [31:0] b, logic [31:0] f, logic [31:0] d);
    int kind;
    logic [31:0] data;
    busPkg::faultCause cause;
    @(posedge clk);
    req <= (o != lsuPkg::opNone);
    op <= o;
    base <= b;
    offset <= f;
    storeData <= d;
    modelAccess(o, b + f, d, kind, data, cause);
    expKind.push_back(kind);
    expData.push_back(data);
    expCause.push_back(cause);
    @(negedge clk);
    if (expKind.size() > 2) begin
      kind = expKind.pop_front();
      data = expData.pop_front();
      cause = expCause.pop_front();
      checkData(kind == 1, data);
      checkFault(cause);
    end
  endtask

  // watchdog
  initial begin
    wait (tableLen > 0);
    #((tableLen + RandCount + 20) * 10);
    $display("watchdog expired before the test finished");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    lsuPkg::memOp randOps [8];
    lsuPkg::memOp ro;
    rst = 1'b1;
    req = 1'b0;
    op = lsuPkg::opNone;
    base = '0;
    offset = '0;
    storeData = '0;
    for (int i = 0; i < `LSU_MEM_WORDS; i++) refMem[i] = '0;
    // word store and load, back to back and spaced
    addRow(lsuPkg::opStr, 32'h0, 32'h0, 32'h11223344);
    addRow(lsuPkg::opLdr, 32'h0, 32'h0, 32'h0);
    addRow(lsuPkg::opStr, 32'h40, 32'h0, 32'hDEADBEEF);
    addRow(lsuPkg::opStr, 32'h48, 32'hFFFFFFFC, 32'hCAFEF00D);
    addRow(lsuPkg::opNone, 32'h0, 32'h0, 32'h0);
    addRow(lsuPkg::opLdr, 32'h40, 32'h0, 32'h0);
    addRow(lsuPkg::opLdr, 32'h44, 32'h0, 32'h0);
    // byte and halfword merges
    addRow(lsuPkg::opStrb, 32'h40, 32'h1, 32'h000000AB);
    addRow(lsuPkg::opStrb, 32'h43, 32'h0, 32'h00000012);
    addRow(lsuPkg::opStrh, 32'h44, 32'h2, 32'h0000BEEF);
    addRow(lsuPkg::opLdr, 32'h40, 32'h0, 32'h0);
    addRow(lsuPkg::opLdr, 32'h44, 32'h0, 32'h0);
    // extension at every lane, top bits set and clear
    addRow(lsuPkg::opStr, 32'h80, 32'h0, 32'h80FF7F01);
    addRow(lsuPkg::opStr, 32'h84, 32'h0, 32'h7FFF8001);
    for (int i = 0; i < 4; i++) begin
      addRow(lsuPkg::opLdrb, 32'h80, i, 32'h0);
      addRow(lsuPkg::opLdrsb, 32'h80, i, 32'h0);
    end
    for (int i = 0; i < 8; i += 2) begin
      addRow(lsuPkg::opLdrh, 32'h80, i, 32'h0);
      addRow(lsuPkg::opLdrsh, 32'h80, i, 32'h0);
    end
    // misaligned accesses leave memory alone
    addRow(lsuPkg::opStrh, 32'h40, 32'h1, 32'h00005555);
    addRow(lsuPkg::opStr, 32'h42, 32'h0, 32'h66666666);
    addRow(lsuPkg::opLdr, 32'h43, 32'h0, 32'h0);
    addRow(lsuPkg::opLdrsh, 32'h83, 32'h0, 32'h0);
    addRow(lsuPkg::opLdr, 32'h40, 32'h0, 32'h0);
    // out of range, last word stays intact
    addRow(lsuPkg::opStr, (`LSU_MEM_WORDS - 1) * 4, 32'h0, 32'h0BADF00D);
    addRow(lsuPkg::opStr, `LSU_MEM_WORDS * 4, 32'h0, 32'h77777777);
    addRow(lsuPkg::opStrb, 32'h3FF0, 32'h13, 32'h00000099);
    addRow(lsuPkg::opLdrb, 32'hFFFFFFF0, 32'hF, 32'h0);
    addRow(lsuPkg::opLdr, (`LSU_MEM_WORDS - 1) * 4, 32'h0, 32'h0);
    // a wrapped word index would land on word 0
    addRow(lsuPkg::opLdr, 32'h0, 32'h0, 32'h0);
    tableLen = tabOp.size();

    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < tableLen; i++) begin
      applyRow(tabOp[i], tabBase[i], tabOff[i], tabData[i]);
    end

    // random phase over a 64-byte window
    randOps = '{lsuPkg::opLdrb, lsuPkg::opLdrsb, lsuPkg::opLdrh, lsuPkg::opLdrsh,
                lsuPkg::opLdr, lsuPkg::opStrb, lsuPkg::opStrh, lsuPkg::opStr};
    for (int i = 0; i < RandCount; i++) begin
      ro = randOps[$unsigned($random(seed)) % 8];
      applyRow(ro, 32'h100, $unsigned($random(seed)) % 64, $random(seed));
    end
    // flush the two accesses still in flight
    repeat (2) applyRow(lsuPkg::opNone, 32'h0, 32'h0, 32'h0);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* lsuTop.f */
+incdir+source
source/lsuPkg.sv
source/busPkg.sv
source/memOpDecoder.sv
source/addressUnit.sv
source/dataMemory.sv
source/loadFormatter.sv
source/lsuTop.sv
verification/lsuTop_chk.sv
verification/lsuTop_tb.sv

/* Makefile */
# Verilator build and run for the load/store path testbench
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Isource
TOP       ?= lsuTop_tb
RTL_TOP   ?= lsuTop
FILELIST  ?= lsuTop.f
OBJDIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST OK"

lint:
	$(VERILATOR) --lint-only --timing -Isource --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
